/* verilog/cpuParams.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath width and register index width
`define CPU_XLEN       32
`define CPU_REG_ADDR_W 5

`define CPU_RESET_PC   32'h3000    // First fetch after reset

// Destination of jal
`define CPU_LINK_REG   31

`endif

/* verilog/cpuPkg.sv */
`default_nettype none
`include "cpuParams.svh"

package cpuPkg;

    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opOri     = 6'b001101,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnJr   = 6'b001000,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011
    } functE;

    typedef enum logic [1:0] {aluAdd, aluSub, aluOr, aluLui} aluOpE;
    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelE;
    typedef enum logic [1:0] {fwdReg, fwdExe, fwdMem, fwdWb} fwdSelE;

    // Cycles left until a result exists, 3 marks an unused source
    typedef logic [1:0] tnewT;

    typedef struct packed {
        opcodeE                     op;
        logic [`CPU_REG_ADDR_W-1:0] rs;
        logic [`CPU_REG_ADDR_W-1:0] rt;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [4:0]                 shamt;
        functE                      funct;
    } rFieldsT;

    typedef struct packed {
        opcodeE                     op;
        logic [`CPU_REG_ADDR_W-1:0] rs;
        logic [`CPU_REG_ADDR_W-1:0] rt;
        logic [15:0]                imm;
    } iFieldsT;

    typedef union packed {
        rFieldsT rFields;
        iFieldsT iFields;
    } instrWord;

    // Register written by an instruction, zero when it writes nothing
    function automatic logic [`CPU_REG_ADDR_W-1:0] writeDest(input instrWord instr);
        case (instr.rFields.op)
            opSpecial: begin
                if (instr.rFields.funct == fnAddu || instr.rFields.funct == fnSubu)
                    return instr.rFields.rd;
                return '0;    // sll and jr
            end
            opOri, opLui, opLw: return instr.iFields.rt;
            opJal: return `CPU_REG_ADDR_W'(`CPU_LINK_REG);
            default: return '0;
        endcase
    endfunction

    function automatic logic [`CPU_XLEN-1:0] fwdPick(
        input fwdSelE               sel,
        input logic [`CPU_XLEN-1:0] fileVal,
        input logic [`CPU_XLEN-1:0] exeVal,
        input logic [`CPU_XLEN-1:0] memVal,
        input logic [`CPU_XLEN-1:0] wbVal
    );
        case (sel)
            fwdExe: return exeVal;
            fwdMem: return memVal;
            fwdWb: return wbVal;
            default: return fileVal;
        endcase
    endfunction

endpackage

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module regFile (
    input  wire                        clk,
    input  wire                        reset,
    input  wire  [`CPU_REG_ADDR_W-1:0] rs,
    input  wire  [`CPU_REG_ADDR_W-1:0] rt,
    output logic [`CPU_XLEN-1:0]       rsVal,
    output logic [`CPU_XLEN-1:0]       rtVal,
    input  wire                        we,
    input  wire  [`CPU_REG_ADDR_W-1:0] dest,
    input  wire  [`CPU_XLEN-1:0]       wdata
);

    localparam int regCount = 1 << `CPU_REG_ADDR_W;

    logic [`CPU_XLEN-1:0] regs [regCount];

    assign rsVal = regs[rs];
    assign rtVal = regs[rt];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && dest != '0) begin
            regs[dest] <= wdata;    // r0 never written
        end
    end

    zeroReadsZero: assert property (@(posedge clk) disable iff (reset) rs == '0 |-> rsVal == '0);

endmodule

`default_nettype wire

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module fetchUnit
    import cpuPkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  stall,
    input  wire                  redirect,
    input  wire  [`CPU_XLEN-1:0] redirectPc,
    input  wire  [`CPU_XLEN-1:0] instRdata,
    output logic [`CPU_XLEN-1:0] instAddr,
    output instrWord             dInstr,
    output logic [`CPU_XLEN-1:0] dPc
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] nextPc;

    assign instAddr = pc;
    assign nextPc   = redirect ? redirectPc : pc + 4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `CPU_RESET_PC;
            dInstr <= '0;    // sll zero acts as nop
        end else if (!stall) begin
            pc     <= nextPc;
            dInstr <= instRdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dPc <= pc;
        end
    end

    // jr targets come from register data, so alignment depends on the program
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* verilog/decodeUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module decodeUnit
    import cpuPkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        stall,
    input  wire instrWord              dInstr,
    input  wire  [`CPU_XLEN-1:0]       dPc,
    input  wire fwdSelE                dRsFwd,
    input  wire fwdSelE                dRtFwd,
    input  wire  [`CPU_XLEN-1:0]       eLinkData,
    input  wire  [`CPU_XLEN-1:0]       mFwdData,
    input  wire  [`CPU_XLEN-1:0]       wData,
    input  wire                        wWe,
    input  wire  [`CPU_REG_ADDR_W-1:0] wDest,
    output logic                       redirect,
    output logic [`CPU_XLEN-1:0]       redirectPc,
    output logic [`CPU_REG_ADDR_W-1:0] dRs,
    output logic [`CPU_REG_ADDR_W-1:0] dRt,
    output tnewT                       dRsTuse,
    output tnewT                       dRtTuse,
    output instrWord                   eInstr,
    output logic [`CPU_XLEN-1:0]       ePc,
    output logic [`CPU_XLEN-1:0]       eRsVal,
    output logic [`CPU_XLEN-1:0]       eRtVal,
    output logic [`CPU_XLEN-1:0]       eImm
);

    opcodeE               op;
    functE                funct;
    logic                 isJr;
    logic [`CPU_XLEN-1:0] rsFile, rtFile;
    logic [`CPU_XLEN-1:0] rsVal, rtVal;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] pcPlus4;

    assign op    = dInstr.rFields.op;
    assign funct = dInstr.rFields.funct;
    assign dRs   = dInstr.iFields.rs;
    assign dRt   = dInstr.iFields.rt;
    assign isJr  = op == opSpecial && funct == fnJr;

    regFile regFile0 (
        .clk   (clk),
        .reset (reset),
        .rs    (dRs),
        .rt    (dRt),
        .rsVal (rsFile),
        .rtVal (rtFile),
        .we    (wWe),
        .dest  (wDest),
        .wdata (wData)
    );

    assign rsVal = fwdPick(dRsFwd, rsFile, eLinkData, mFwdData, wData);
    assign rtVal = fwdPick(dRtFwd, rtFile, eLinkData, mFwdData, wData);

    // ori and lui take the raw immediate
    assign imm = (op == opOri || op == opLui) ? {16'b0, dInstr.iFields.imm}
                                              : {{16{dInstr.iFields.imm[15]}}, dInstr.iFields.imm};

    always_comb begin
        dRsTuse = 2'd3;
        dRtTuse = 2'd3;
        case (op)
            opSpecial: begin
                if (isJr) dRsTuse = 2'd0;
                if (funct == fnAddu || funct == fnSubu) begin
                    dRsTuse = 2'd1;
                    dRtTuse = 2'd1;
                end
            end
            opBeq: begin
                dRsTuse = 2'd0;
                dRtTuse = 2'd0;
            end
            opOri, opLw: dRsTuse = 2'd1;
            opSw: begin
                dRsTuse = 2'd1;
                dRtTuse = 2'd1;    // Store data settles in execute
            end
            default: ;
        endcase
    end

    assign pcPlus4  = dPc + 4;
    assign redirect = (op == opBeq && rsVal == rtVal) || op == opJal || isJr;

    always_comb begin
        if (isJr)
            redirectPc = rsVal;
        else if (op == opJal)
            redirectPc = {pcPlus4[31:28], dInstr.iFields.rs, dInstr.iFields.rt,
                          dInstr.iFields.imm, 2'b00};
        else
            redirectPc = pcPlus4 + {imm[29:0], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            eInstr <= '0;    // Bubble
        end else begin
            eInstr <= dInstr;
        end
    end

    always_ff @(posedge clk) begin
        ePc    <= dPc;
        eRsVal <= rsVal;
        eRtVal <= rtVal;
        eImm   <= imm;
    end

endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module hazardUnit
    import cpuPkg::*;
(
    input  wire  [`CPU_REG_ADDR_W-1:0] dRs,
    input  wire  [`CPU_REG_ADDR_W-1:0] dRt,
    input  wire tnewT                  dRsTuse,
    input  wire tnewT                  dRtTuse,
    input  wire  [`CPU_REG_ADDR_W-1:0] eRs,
    input  wire  [`CPU_REG_ADDR_W-1:0] eRt,
    input  wire  [`CPU_REG_ADDR_W-1:0] eDest,
    input  wire tnewT                  eTnew,
    input  wire                        eWe,
    input  wire  [`CPU_REG_ADDR_W-1:0] mDest,
    input  wire tnewT                  mTnew,
    input  wire                        mWe,
    input  wire  [`CPU_REG_ADDR_W-1:0] wDest,
    input  wire                        wWe,
    output logic                       stall,
    output fwdSelE                     dRsFwd,
    output fwdSelE                     dRtFwd,
    output fwdSelE                     eRsFwd,
    output fwdSelE                     eRtFwd
);

    // Producer in flight whose result comes later than the source is needed
    function automatic logic srcStalls(input logic [`CPU_REG_ADDR_W-1:0] src, input tnewT tuse);
        return src != '0 && ((src == eDest && eWe && eTnew > tuse) ||
                             (src == mDest && mWe && mTnew > tuse));
    endfunction

    function automatic fwdSelE pickSource(input logic [`CPU_REG_ADDR_W-1:0] src,
                                          input logic fromExe);
        if (src == '0) return fwdReg;
        if (fromExe && src == eDest && eWe && eTnew == 2'd0) return fwdExe;
        if (src == mDest && mWe && mTnew == 2'd0) return fwdMem;
        if (src == wDest && wWe) return fwdWb;
        return fwdReg;
    endfunction

    always_comb begin
        stall  = srcStalls(dRs, dRsTuse) || srcStalls(dRt, dRtTuse);
        dRsFwd = pickSource(dRs, 1'b1);
        dRtFwd = pickSource(dRt, 1'b1);
        eRsFwd = pickSource(eRs, 1'b0);    // Execute sees only memory and write-back
        eRtFwd = pickSource(eRt, 1'b0);
    end

endmodule

`default_nettype wire

/* verilog/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module executeUnit
    import cpuPkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire instrWord              eInstr,
    input  wire  [`CPU_XLEN-1:0]       ePc,
    input  wire  [`CPU_XLEN-1:0]       eRsVal,
    input  wire  [`CPU_XLEN-1:0]       eRtVal,
    input  wire  [`CPU_XLEN-1:0]       eImm,
    input  wire fwdSelE                eRsFwd,
    input  wire fwdSelE                eRtFwd,
    input  wire  [`CPU_XLEN-1:0]       mFwdData,
    input  wire  [`CPU_XLEN-1:0]       wData,
    output logic [`CPU_REG_ADDR_W-1:0] eRs,
    output logic [`CPU_REG_ADDR_W-1:0] eRt,
    output logic [`CPU_REG_ADDR_W-1:0] eDest,
    output tnewT                       eTnew,
    output logic                       eWe,
    output logic [`CPU_XLEN-1:0]       eLinkData,
    output instrWord                   mInstr,
    output logic [`CPU_XLEN-1:0]       mPc,
    output logic [`CPU_XLEN-1:0]       mAluRes,
    output logic [`CPU_XLEN-1:0]       mRtVal
);

    aluOpE                aluOp;
    logic                 useImm;
    logic [`CPU_XLEN-1:0] rsOp, rtOp, srcB, aluRes;

    assign eRs       = eInstr.rFields.rs;
    assign eRt       = eInstr.rFields.rt;
    assign eDest     = writeDest(eInstr);    // rd, rt or the link register
    assign eWe       = eDest != '0;
    assign eLinkData = ePc + 8;

    assign rsOp = fwdPick(eRsFwd, eRsVal, '0, mFwdData, wData);
    assign rtOp = fwdPick(eRtFwd, eRtVal, '0, mFwdData, wData);

    always_comb begin
        aluOp  = aluAdd;    // lw, sw and the rest use address add
        useImm = 1'b1;
        eTnew  = 2'd1;
        case (eInstr.rFields.op)
            opSpecial: begin
                useImm = 1'b0;
                if (eInstr.rFields.funct == fnSubu) aluOp = aluSub;
            end
            opOri: aluOp = aluOr;
            opLui: aluOp = aluLui;
            opLw: eTnew = 2'd2;
            opJal: eTnew = 2'd0;    // Link value is known already
            default: ;
        endcase
    end

    assign srcB = useImm ? eImm : rtOp;

    always_comb begin
        case (aluOp)
            aluAdd: aluRes = rsOp + srcB;
            aluSub: aluRes = rsOp - srcB;
            aluOr: aluRes = rsOp | srcB;
            default: aluRes = {srcB[15:0], 16'b0};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mInstr <= '0;
        end else begin
            mInstr <= eInstr;
        end
    end

    always_ff @(posedge clk) begin
        mPc     <= ePc;
        mAluRes <= aluRes;
        mRtVal  <= rtOp;
    end

endmodule

`default_nettype wire

/* verilog/memoryUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module memoryUnit
    import cpuPkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire instrWord              mInstr,
    input  wire  [`CPU_XLEN-1:0]       mPc,
    input  wire  [`CPU_XLEN-1:0]       mAluRes,
    input  wire  [`CPU_XLEN-1:0]       mRtVal,
    input  wire  [`CPU_XLEN-1:0]       dataRdata,
    output logic [`CPU_XLEN-1:0]       dataAddr,
    output logic [`CPU_XLEN-1:0]       dataWdata,
    output logic                       dataWe,
    output logic [`CPU_REG_ADDR_W-1:0] mDest,
    output tnewT                       mTnew,
    output logic                       mWe,
    output logic [`CPU_XLEN-1:0]       mFwdData,
    output logic [`CPU_REG_ADDR_W-1:0] wDest,
    output logic                       wWe,
    output logic [`CPU_XLEN-1:0]       wData,
    output logic [`CPU_XLEN-1:0]       wPc
);

    wbSelE                wbSel;
    logic [`CPU_XLEN-1:0] linkData;
    logic [`CPU_XLEN-1:0] wbValue;

    assign dataAddr  = mAluRes;
    assign dataWdata = mRtVal;
    assign dataWe    = mInstr.rFields.op == opSw;

    assign mDest    = writeDest(mInstr);
    assign mWe      = mDest != '0;
    assign mTnew    = (mInstr.rFields.op == opLw) ? 2'd1 : 2'd0;
    assign linkData = mPc + 8;

    always_comb begin
        case (mInstr.rFields.op)
            opLw: wbSel = wbMem;
            opJal: wbSel = wbLink;
            default: wbSel = wbAlu;
        endcase
    end

    // Load data is not ready for forwarding until write-back
    assign mFwdData = (wbSel == wbLink) ? linkData : mAluRes;
    assign wbValue  = (wbSel == wbMem) ? dataRdata : mFwdData;

    always_ff @(posedge clk) begin
        if (reset) begin
            wWe   <= 1'b0;
            wDest <= '0;
        end else begin
            wWe   <= mWe;
            wDest <= mDest;
        end
    end

    always_ff @(posedge clk) begin
        wData <= wbValue;
        wPc   <= mPc;
    end

    storeAligned: assert property (@(posedge clk) disable iff (reset)
        dataWe |-> dataAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module cpu
    import cpuPkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire  [`CPU_XLEN-1:0]       instRdata,
    input  wire  [`CPU_XLEN-1:0]       dataRdata,
    output logic [`CPU_XLEN-1:0]       instAddr,
    output logic [`CPU_XLEN-1:0]       dataAddr,
    output logic [`CPU_XLEN-1:0]       dataWdata,
    output logic                       dataWe,
    output logic                       grfWe,
    output logic [`CPU_REG_ADDR_W-1:0] grfAddr,
    output logic [`CPU_XLEN-1:0]       grfWdata,
    output logic [`CPU_XLEN-1:0]       wbPc
);

    logic                       stall;
    logic                       redirect;
    logic [`CPU_XLEN-1:0]       redirectPc;
    instrWord                   dInstr, eInstr, mInstr;
    logic [`CPU_XLEN-1:0]       dPc, ePc, mPc, wPc;
    fwdSelE                     dRsFwd, dRtFwd, eRsFwd, eRtFwd;
    logic [`CPU_REG_ADDR_W-1:0] dRs, dRt, eRs, eRt;
    tnewT                       dRsTuse, dRtTuse;
    logic [`CPU_XLEN-1:0]       eRsVal, eRtVal, eImm, eLinkData;
    logic [`CPU_REG_ADDR_W-1:0] eDest, mDest, wDest;
    tnewT                       eTnew, mTnew;
    logic                       eWe, mWe, wWe;
    logic [`CPU_XLEN-1:0]       mAluRes, mRtVal, mFwdData, wData;

    fetchUnit fetchUnit0 (.*);

    decodeUnit decodeUnit0 (.*);

    executeUnit executeUnit0 (.*);

    memoryUnit memoryUnit0 (.*);

    hazardUnit hazardUnit0 (.*);

    // Write-back trace
    assign grfWe    = wWe;
    assign grfAddr  = wDest;
    assign grfWdata = wData;
    assign wbPc     = wPc;

endmodule

`default_nettype wire

/* sim/cpuTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpuParams.svh"

module cpuTb;

    localparam int imemWords   = 64;
    localparam int dmemWords   = 256;
    localparam int testLimit   = 100;
    localparam int drainCycles = 4;
    // Five tests, each with its trace limit plus reset, drain and margin
    localparam int runLimit    = 5 * (testLimit + 20);

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;
    localparam logic [5:0] fnJr      = 6'h08;
    localparam logic [5:0] fnAddu    = 6'h21;
    localparam logic [5:0] fnSubu    = 6'h23;

    logic                       clk;
    logic                       reset;
    logic [`CPU_XLEN-1:0]       instAddr, instRdata;
    logic [`CPU_XLEN-1:0]       dataAddr, dataRdata, dataWdata;
    logic                       dataWe;
    logic                       grfWe;
    logic [`CPU_REG_ADDR_W-1:0] grfAddr;
    logic [`CPU_XLEN-1:0]       grfWdata, wbPc;

    logic [31:0] imem [imemWords];
    logic [31:0] dmem [dmemWords];
    logic [31:0] instIdx, dataIdx;

    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] expPc [$];

    string       testName;
    int          errors;
    int          errorsAtStart;
    int          testsRun;
    int          failedTests;
    int          firstWriteCycle;
    int          cycleCount = 0;
    logic [31:0] rngState;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    cpu dut0 (
        .clk       (clk),
        .reset     (reset),
        .instRdata (instRdata),
        .dataRdata (dataRdata),
        .instAddr  (instAddr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .grfWe     (grfWe),
        .grfAddr   (grfAddr),
        .grfWdata  (grfWdata),
        .wbPc      (wbPc)
    );

    // Both memories answer in the same cycle, outside the arrays they read as zero
    assign instIdx   = (instAddr - `CPU_RESET_PC) >> 2;
    assign instRdata = (instIdx < imemWords) ? imem[instIdx[5:0]] : 32'h0;
    assign dataIdx   = dataAddr >> 2;
    assign dataRdata = (dataIdx < dmemWords) ? dmem[dataIdx[7:0]] : 32'h0;

    always @(posedge clk) begin
        if (dataWe && dataIdx < dmemWords) begin
            dmem[dataIdx[7:0]] <= dataWdata;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= runLimit) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycleCount);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] funct);
        return {opSpecial, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] pcAt(input int slot);
        return `CPU_RESET_PC + 32'(slot) * 4;
    endfunction

    // Odd multiplier spreads every address bit over the word
    function automatic logic [31:0] fillWord(input int idx);
        return (32'(idx) << 2) * 32'h9e3779b1;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: %s expected %h, actual %h", testName, what, expected, actual);
            errors++;
        end
    endtask

    task automatic expectWrite(input logic [4:0] addr, input logic [31:0] data, input int slot);
        expAddr.push_back(32'(addr));
        expData.push_back(data);
        expPc.push_back(pcAt(slot));
    endtask

    task automatic beginTest(input string name);
        testName      = name;
        errorsAtStart = errors;
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = 32'h0;    // sll zero
        end
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = fillWord(i);
        end
        expAddr.delete();
        expData.delete();
        expPc.delete();
    endtask

    // Holds reset two cycles, then follows the write-back trace
    task automatic runTrace();
        int cyc;
        cyc             = 0;
        firstWriteCycle = 0;
        repeat (2) @(posedge clk);
        #1;
        checkValue("grfWe during reset", 32'h0, 32'(grfWe));
        reset = 1'b0;
        while (expAddr.size() > 0 && cyc < testLimit) begin
            @(negedge clk);
            cyc++;
            if (grfWe) begin
                if (firstWriteCycle == 0) firstWriteCycle = cyc;
                checkValue("wbPc", expPc[0], wbPc);
                checkValue("grfAddr", expAddr[0], 32'(grfAddr));
                checkValue("grfWdata", expData[0], grfWdata);
                void'(expAddr.pop_front());
                void'(expData.pop_front());
                void'(expPc.pop_front());
            end
        end
        if (expAddr.size() > 0) begin
            $display("%s: %0d register writes never appeared within %0d cycles",
                     testName, expAddr.size(), testLimit);
            errors++;
        end
        repeat (drainCycles) begin
            @(negedge clk);
            if (grfWe) begin
                $display("%s: unexpected write to r%0d from pc %h", testName, grfAddr, wbPc);
                errors++;
            end
        end
    endtask

    task automatic endTest();
        testsRun++;
        if (errors == errorsAtStart) begin
            $display("test %s: ok", testName);
        end else begin
            failedTests++;
            $display("test %s: %0d errors", testName, errors - errorsAtStart);
        end
    endtask

    task automatic resetTraceTest();
        logic [31:0] r;
        beginTest("resetTrace");
        for (int i = 0; i < 4; i++) begin
            r       = nextRandom();
            imem[i] = encI(opOri, 5'd0, 5'(i + 1), r[15:0]);
            expectWrite(5'(i + 1), {16'h0, r[15:0]}, i);
        end
        runTrace();
        // Decode, execute, memory and write-back edges after reset release
        checkValue("first write cycle", 32'd5, 32'(firstWriteCycle));
        checkValue("dmem[0]", fillWord(0), dmem[0]);
        endTest();
    endtask

    task automatic chainTest();
        logic [31:0] a, b, c, r1, r2, r3, r4, r5;
        beginTest("chain");
        a  = nextRandom();
        b  = nextRandom();
        c  = nextRandom();
        r1 = {a[15:0], 16'h0};
        imem[0] = encI(opLui, 5'd0, 5'd1, a[15:0]);
        expectWrite(5'd1, r1, 0);
        r1 = r1 | {16'h0, b[15:0]};
        imem[1] = encI(opOri, 5'd1, 5'd1, b[15:0]);
        expectWrite(5'd1, r1, 1);
        r2 = r1 + r1;
        imem[2] = encR(5'd1, 5'd1, 5'd2, fnAddu);
        expectWrite(5'd2, r2, 2);
        r3 = {16'h0, c[15:0]};
        imem[3] = encI(opOri, 5'd0, 5'd3, c[15:0]);
        expectWrite(5'd3, r3, 3);
        r4 = r2 - r3;
        imem[4] = encR(5'd2, 5'd3, 5'd4, fnSubu);
        expectWrite(5'd4, r4, 4);
        r5 = r4 + r1;
        imem[5] = encR(5'd4, 5'd1, 5'd5, fnAddu);
        expectWrite(5'd5, r5, 5);
        imem[6] = encI(opSw, 5'd0, 5'd5, 16'h0);
        runTrace();
        checkValue("dmem[0]", r5, dmem[0]);
        endTest();
    endtask

    task automatic loadUseTest();
        logic [31:0] x;
        beginTest("loadUse");
        x = nextRandom() >> 16;
        imem[0] = encI(opOri, 5'd0, 5'd1, x[15:0]);
        imem[1] = encI(opOri, 5'd0, 5'd2, 16'h0040);
        imem[2] = encI(opSw, 5'd2, 5'd1, 16'h0);
        imem[3] = encI(opLw, 5'd2, 5'd3, 16'h0);
        imem[4] = encR(5'd3, 5'd1, 5'd4, fnAddu);    // Needs the loaded word at once
        expectWrite(5'd1, x, 0);
        expectWrite(5'd2, 32'h40, 1);
        expectWrite(5'd3, x, 3);
        expectWrite(5'd4, x + x, 4);
        runTrace();
        checkValue("dmem[16]", x, dmem[16]);
        endTest();
    endtask

    task automatic branchTest();
        beginTest("branch");
        imem[0] = encI(opOri, 5'd0, 5'd1, 16'h5);
        imem[1] = encI(opOri, 5'd0, 5'd2, 16'h5);
        imem[2] = encI(opBeq, 5'd1, 5'd2, 16'd2);    // Taken to slot 5
        imem[3] = encI(opOri, 5'd0, 5'd3, 16'h11);
        imem[4] = encI(opOri, 5'd0, 5'd4, 16'h22);
        imem[5] = encI(opOri, 5'd0, 5'd5, 16'h33);
        imem[6] = encI(opBeq, 5'd1, 5'd5, 16'd2);    // Not taken
        imem[7] = encI(opOri, 5'd0, 5'd6, 16'h44);
        imem[8] = encI(opOri, 5'd0, 5'd7, 16'h55);
        expectWrite(5'd1, 32'h5, 0);
        expectWrite(5'd2, 32'h5, 1);
        expectWrite(5'd3, 32'h11, 3);
        expectWrite(5'd5, 32'h33, 5);
        expectWrite(5'd6, 32'h44, 7);
        expectWrite(5'd7, 32'h55, 8);
        runTrace();
        checkValue("dmem[0]", fillWord(0), dmem[0]);
        endTest();
    endtask

    task automatic jumpLinkTest();
        beginTest("jumpLink");
        imem[0]  = encI(opOri, 5'd0, 5'd1, 16'h7);
        imem[1]  = encJ(opJal, pcAt(8));
        imem[2]  = encI(opOri, 5'd0, 5'd2, 16'h21);
        imem[3]  = encI(opOri, 5'd0, 5'd3, 16'h31);    // Return point
        imem[4]  = encR(5'd3, 5'd1, 5'd4, fnAddu);
        imem[5]  = encI(opSw, 5'd0, 5'd4, 16'h8);
        imem[6]  = encI(opBeq, 5'd0, 5'd0, 16'hffff);  // Spin here
        imem[8]  = encR(5'd31, 5'd0, 5'd0, fnJr);
        imem[9]  = encI(opOri, 5'd0, 5'd5, 16'h55);
        imem[10] = encI(opOri, 5'd0, 5'd6, 16'h66);
        expectWrite(5'd1, 32'h7, 0);
        expectWrite(5'd31, pcAt(1) + 8, 1);
        expectWrite(5'd2, 32'h21, 2);
        expectWrite(5'd5, 32'h55, 9);
        expectWrite(5'd3, 32'h31, 3);
        expectWrite(5'd4, 32'h38, 4);
        runTrace();
        checkValue("dmem[2]", 32'h38, dmem[2]);
        endTest();
    endtask

    initial begin
        rngState    = 32'h6655293f;
        reset       = 1'b1;
        errors      = 0;
        testsRun    = 0;
        failedTests = 0;
        for (int i = 0; i < imemWords; i++) begin
            imem[i] = 32'h0;
        end
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = fillWord(i);
        end
        resetTraceTest();
        chainTest();
        loadUseTest();
        branchTest();
        jumpLinkTest();
        $display("%0d tests run, %0d failed, %0d check errors", testsRun, failedTests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/fetchUnit.sv
verilog/decodeUnit.sv
verilog/hazardUnit.sv
verilog/executeUnit.sv
verilog/memoryUnit.sv
verilog/cpu.sv
sim/cpuTb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := cpuTb
FILELIST := verilog.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
